// File: hw/edge_macros.svh
`ifndef EDGE_MACROS_SVH
`define EDGE_MACROS_SVH

// image geometry, also runs at 160 x 120
`define EDGE_IMG_COLS     32
`define EDGE_IMG_ROWS     24
`define EDGE_IMG_PXLS     (`EDGE_IMG_COLS * `EDGE_IMG_ROWS)

`define EDGE_NB_PXL       8                          // grey bits
`define EDGE_NB_ADDR      $clog2(`EDGE_IMG_PXLS)     // linear pixel address
`define EDGE_NB_COLS      $clog2(`EDGE_IMG_COLS)
`define EDGE_NB_ROWS      $clog2(`EDGE_IMG_ROWS)

// host register map
`define EDGE_NB_REG_ADDR  2
`define EDGE_NB_REG_DATA  8
`define EDGE_REG_CTRL     0    // filter_on, vfilter, run
`define EDGE_REG_FRAMES   1    // frame counter, read only

`endif

// File: hw/edge_pkg.sv
`include "edge_macros.svh"

package edge_pkg;

  // one grey level
  typedef logic [`EDGE_NB_PXL-1:0]  pxl_t;

  // linear address into a frame memory
  typedef logic [`EDGE_NB_ADDR-1:0] pxl_addr_t;

  // position of the kernel centre
  typedef logic [`EDGE_NB_COLS-1:0] col_t;
  typedef logic [`EDGE_NB_ROWS-1:0] row_t;

  // weights 1 2 1 over three pixels need two more bits
  typedef logic [`EDGE_NB_PXL+1:0]  sum_t;

  // host register bus
  typedef logic [`EDGE_NB_REG_ADDR-1:0] reg_addr_t;
  typedef logic [`EDGE_NB_REG_DATA-1:0] reg_data_t;

endpackage

// File: hw/kernel_if.sv
`timescale 1ns/1ps

interface kernel_if;
  import edge_pkg::*;

  // window layout, p22 is the newest pixel
  //  p00 p01 p02   row above
  //  p10 p11 p12   centre row
  //  p20 p21 p22   row below
  pxl_t      p00, p01, p02;
  pxl_t      p10, p11, p12;
  pxl_t      p20, p21, p22;
  logic      border;      // centre pixel sits on the image edge
  pxl_addr_t pxl_in_num;  // number of the pixel entering the window
  logic      receiving;   // window shifts on this cycle

  modport win (
    output p00, p01, p02,
    output p10, p11, p12,
    output p20, p21, p22,
    output border, pxl_in_num, receiving
  );

  modport calc (
    input  p00, p01, p02,
    input  p10, p11, p12,
    input  p20, p21, p22,
    input  border, pxl_in_num, receiving
  );

endinterface

// File: hw/frame_ram.sv
`timescale 1ns/1ps
`include "edge_macros.svh"

module frame_ram (
  input  logic                rst,    // clock
  input  logic                we,
  input  edge_pkg::pxl_addr_t waddr,
  input  edge_pkg::pxl_t      wdata,
  input  edge_pkg::pxl_addr_t raddr,
  output edge_pkg::pxl_t      rdata
);
  import edge_pkg::*;

  // one full frame, maps to block ram
  pxl_t mem [0:`EDGE_IMG_PXLS-1];

  // write port
  always_ff @(posedge rst) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read port, data one clock after the address
  always_ff @(posedge rst) begin
    rdata <= mem[raddr];
  end

endmodule

// File: hw/edge_cfg_regs.sv
`timescale 1ns/1ps
`include "edge_macros.svh"

module edge_cfg_regs (
  input  logic                rst,         // clock
  input  logic                clk,         // async reset, active high
  input  logic                cfg_we,
  input  edge_pkg::reg_addr_t cfg_addr,
  input  edge_pkg::reg_data_t cfg_wdata,
  output edge_pkg::reg_data_t cfg_rdata,
  input  logic                frame_done,  // one pulse per written frame
  output logic                filter_on,
  output logic                vfilter,
  output logic                run
);
  import edge_pkg::*;

  localparam reg_addr_t CTRL_ADDR   = reg_addr_t'(`EDGE_REG_CTRL);
  localparam reg_addr_t FRAMES_ADDR = reg_addr_t'(`EDGE_REG_FRAMES);

  // control bit positions
  localparam int BIT_FILTER = 0;
  localparam int BIT_VFILT  = 1;
  localparam int BIT_RUN    = 2;

  logic [2:0] ctrl_q;    // run, vfilter, filter_on
  reg_data_t  frames_q;  // completed frames, wraps past 255

  // control register, takes the write at the next edge
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      ctrl_q <= '0;
    end else if (cfg_we && (cfg_addr == CTRL_ADDR)) begin
      ctrl_q <= cfg_wdata[2:0];
    end
  end

  // frame counter
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      frames_q <= '0;
    end else if (frame_done) begin
      frames_q <= frames_q + reg_data_t'(1);
    end
  end

  // read mux, no latency
  always_comb begin
    case (cfg_addr)
      CTRL_ADDR:   cfg_rdata = reg_data_t'(ctrl_q);
      FRAMES_ADDR: cfg_rdata = frames_q;
      default:     cfg_rdata = '0;  // unmapped
    endcase
  end

  assign filter_on = ctrl_q[BIT_FILTER];
  assign vfilter   = ctrl_q[BIT_VFILT];   // 1 vertical, 0 horizontal
  assign run       = ctrl_q[BIT_RUN];

endmodule

// File: hw/sobel_window.sv
`timescale 1ns/1ps
`include "edge_macros.svh"

module sobel_window (
  input  logic                rst,        // clock
  input  logic                clk,        // async reset, active high
  input  logic                run,
  output edge_pkg::pxl_addr_t orig_addr,  // original memory read address
  input  edge_pkg::pxl_t      orig_pxl,   // one clock after orig_addr
  kernel_if.win               kern
);
  import edge_pkg::*;

  // three kernel pixels of each row sit outside the line buffers
  localparam int        BUF_DEPTH = `EDGE_IMG_COLS - 3;
  localparam col_t      BUF_LAST  = col_t'(BUF_DEPTH - 1);
  localparam pxl_addr_t LAST_PXL  = pxl_addr_t'(`EDGE_IMG_PXLS - 1);
  // entering pixel number while the last frame pixel is at p11
  localparam pxl_addr_t LAST_P11_IN = pxl_addr_t'(`EDGE_IMG_COLS + 1);
  localparam col_t      LAST_COL  = col_t'(`EDGE_IMG_COLS - 1);
  localparam row_t      LAST_ROW  = row_t'(`EDGE_IMG_ROWS - 1);

  pxl_addr_t cnt_pxl;      // scan address
  pxl_addr_t pxl_in_num;   // scan address delayed by the memory latency
  logic      receiving;
  col_t      buf_pt;       // line buffer pointer
  col_t      colnum;       // centre column
  row_t      rownum;       // centre row
  logic      lastpxl_p11;
  logic      first_col, last_col, first_row, last_row;

  pxl_t linebuf1 [0:BUF_DEPTH-1];  // feeds the centre row
  pxl_t linebuf2 [0:BUF_DEPTH-1];  // feeds the row above

  pxl_t p00, p01, p02;
  pxl_t p10, p11, p12;
  pxl_t p20, p21, p22;

  // scan counter, holds while run is low
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cnt_pxl    <= '0;
      pxl_in_num <= '0;
      receiving  <= 1'b0;
    end else begin
      receiving <= run;            // memory data arrives a cycle later
      if (run) begin
        pxl_in_num <= cnt_pxl;
        if (cnt_pxl == LAST_PXL)
          cnt_pxl <= '0;           // wrap at end of frame
        else
          cnt_pxl <= cnt_pxl + 1'b1;
      end
    end
  end

  assign orig_addr   = cnt_pxl;
  assign lastpxl_p11 = (pxl_in_num == LAST_P11_IN);

  // buffer pointer
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      buf_pt <= '0;
    end else if (receiving) begin
      if (buf_pt == BUF_LAST)
        buf_pt <= '0;
      else
        buf_pt <= buf_pt + 1'b1;
    end
  end

  // position of p11, avoids any divide by the image width
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      colnum <= '0;
      rownum <= '0;
    end else if (receiving) begin
      if (lastpxl_p11) begin       // last centre of the frame
        colnum <= '0;
        rownum <= '0;
      end else if (last_col) begin
        colnum <= '0;
        rownum <= rownum + 1'b1;
      end else begin
        colnum <= colnum + 1'b1;
      end
    end
  end

  assign first_col = (colnum == '0);
  assign last_col  = (colnum == LAST_COL);
  assign first_row = (rownum == '0);
  assign last_row  = (rownum == LAST_ROW);

  // kernel shift and line buffer recirculation
  always_ff @(posedge rst) begin
    if (receiving) begin
      linebuf1[buf_pt] <= p20;     // row below moves up one row
      linebuf2[buf_pt] <= p10;     // centre row moves up one row
      p22 <= orig_pxl;             // newest pixel
      p21 <= p22;
      p20 <= p21;
      p12 <= linebuf1[buf_pt];     // old value, written cols-3 shifts ago
      p11 <= p12;
      p10 <= p11;
      p02 <= linebuf2[buf_pt];
      p01 <= p02;
      p00 <= p01;
    end
  end

  assign kern.p00 = p00;
  assign kern.p01 = p01;
  assign kern.p02 = p02;
  assign kern.p10 = p10;
  assign kern.p11 = p11;
  assign kern.p12 = p12;
  assign kern.p20 = p20;
  assign kern.p21 = p21;
  assign kern.p22 = p22;

  assign kern.border     = first_col | last_col | first_row | last_row;
  assign kern.pxl_in_num = pxl_in_num;
  assign kern.receiving  = receiving;

endmodule

// File: hw/sobel_calc.sv
`timescale 1ns/1ps
`include "edge_macros.svh"

module sobel_calc (
  input  logic                rst,        // clock
  input  logic                clk,        // async reset, active high
  kernel_if.calc              kern,
  input  logic                filter_on,  // 0 passes the pixel through
  input  logic                vfilter,    // 1 vertical, 0 horizontal
  output logic                proc_we,
  output edge_pkg::pxl_addr_t proc_addr,
  output edge_pkg::pxl_t      proc_pxl,
  output logic                frame_done
);
  import edge_pkg::*;

  // centre lags the entering pixel by one row, two pixels and the sum register
  localparam pxl_addr_t LAT_PXLS  = pxl_addr_t'(`EDGE_IMG_COLS + 3);
  localparam pxl_addr_t WRAP_OFFS = pxl_addr_t'(`EDGE_IMG_PXLS - `EDGE_IMG_COLS - 3);
  localparam pxl_addr_t LAST_PXL  = pxl_addr_t'(`EDGE_IMG_PXLS - 1);

  sum_t hsum_top, hsum_bot;       // row above, row below
  sum_t vsum_left, vsum_right;    // left and right columns
  sum_t hsum_top_rg, hsum_bot_rg;
  sum_t vsum_left_rg, vsum_right_rg;
  logic border_rg;                // border flag aligned with the sums
  pxl_t sobel_hor, sobel_ver;

  // a + 2b + c
  function automatic sum_t weigh3(input pxl_t a, input pxl_t b, input pxl_t c);
    return sum_t'(a) + (sum_t'(b) << 1) + sum_t'(c);
  endfunction

  // |a - b| capped at the top grey level
  function automatic pxl_t sat_absdiff(input sum_t a, input sum_t b);
    sum_t diff;
    diff = (a > b) ? (a - b) : (b - a);
    if (|diff[`EDGE_NB_PXL+1:`EDGE_NB_PXL])
      return '1;
    return diff[`EDGE_NB_PXL-1:0];
  endfunction

  assign hsum_top   = weigh3(kern.p00, kern.p01, kern.p02);
  assign hsum_bot   = weigh3(kern.p20, kern.p21, kern.p22);
  assign vsum_left  = weigh3(kern.p00, kern.p10, kern.p20);
  assign vsum_right = weigh3(kern.p02, kern.p12, kern.p22);

  // segmentation stage, steps with the window
  always_ff @(posedge rst) begin
    if (kern.receiving) begin
      hsum_top_rg   <= hsum_top;
      hsum_bot_rg   <= hsum_bot;
      vsum_left_rg  <= vsum_left;
      vsum_right_rg <= vsum_right;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      border_rg <= 1'b0;
    else if (kern.receiving)
      border_rg <= kern.border;
  end

  assign sobel_hor = sat_absdiff(hsum_bot_rg, hsum_top_rg);
  assign sobel_ver = sat_absdiff(vsum_right_rg, vsum_left_rg);

  // output select
  always_comb begin
    if (!filter_on)
      proc_pxl = kern.p10;          // centre of the previous shift
    else if (border_rg)
      proc_pxl = '0;                // one pixel frame forced black
    else if (vfilter)
      proc_pxl = sobel_ver;
    else
      proc_pxl = sobel_hor;
  end

  // write address, entering number minus the latency, modulo the frame
  assign proc_addr = (kern.pxl_in_num >= LAT_PXLS) ? (kern.pxl_in_num - LAT_PXLS)
                                                    : (kern.pxl_in_num + WRAP_OFFS);

  assign proc_we    = kern.receiving;
  assign frame_done = kern.receiving && (proc_addr == LAST_PXL);  // last pixel written

endmodule

// File: hw/edge_proc_top.sv
`timescale 1ns/1ps

module edge_proc_top (
  input  logic                rst,        // clock
  input  logic                clk,        // async reset, active high
  // host image load
  input  logic                load_we,
  input  edge_pkg::pxl_addr_t load_addr,
  input  edge_pkg::pxl_t      load_pxl,
  // host read back of the processed frame
  input  edge_pkg::pxl_addr_t rd_addr,
  output edge_pkg::pxl_t      rd_pxl,     // one clock after rd_addr
  // host registers
  input  logic                cfg_we,
  input  edge_pkg::reg_addr_t cfg_addr,
  input  edge_pkg::reg_data_t cfg_wdata,
  output edge_pkg::reg_data_t cfg_rdata,
  output logic                frame_done
);
  import edge_pkg::*;

  pxl_addr_t orig_addr;   // engine scan address
  pxl_t      orig_pxl;
  logic      proc_we;
  pxl_addr_t proc_addr;
  pxl_t      proc_pxl;
  logic      filter_on;
  logic      vfilter;
  logic      run;

  kernel_if u_kern ();    // window to calculator

  // original image
  frame_ram u_orig_ram (
    .rst   (rst),
    .we    (load_we),
    .waddr (load_addr),
    .wdata (load_pxl),
    .raddr (orig_addr),
    .rdata (orig_pxl)
  );

  // processed image
  frame_ram u_proc_ram (
    .rst   (rst),
    .we    (proc_we),
    .waddr (proc_addr),
    .wdata (proc_pxl),
    .raddr (rd_addr),
    .rdata (rd_pxl)
  );

  edge_cfg_regs u_cfg_regs (
    .rst        (rst),
    .clk        (clk),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .frame_done (frame_done),
    .filter_on  (filter_on),
    .vfilter    (vfilter),
    .run        (run)
  );

  sobel_window u_window (
    .rst       (rst),
    .clk       (clk),
    .run       (run),
    .orig_addr (orig_addr),
    .orig_pxl  (orig_pxl),
    .kern      (u_kern.win)
  );

  sobel_calc u_calc (
    .rst        (rst),
    .clk        (clk),
    .kern       (u_kern.calc),
    .filter_on  (filter_on),
    .vfilter    (vfilter),
    .proc_we    (proc_we),
    .proc_addr  (proc_addr),
    .proc_pxl   (proc_pxl),
    .frame_done (frame_done)
  );

endmodule

// File: dv/tb_edge_model.svh
`ifndef TB_EDGE_MODEL_SVH
`define TB_EDGE_MODEL_SVH

// reference Sobel over img[], which the testbench declares before the include
localparam int MAX_GREY = (1 << `EDGE_NB_PXL) - 1;

// pixel at row r, column c of the loaded image
function automatic int px(input int r, input int c);
  return int'(img[r * `EDGE_IMG_COLS + c]);
endfunction

// weights 1 2 1
function automatic int tri_sum(input int a, input int b, input int c);
  return a + 2 * b + c;
endfunction

// magnitude, capped at white
function automatic int cap_abs(input int d);
  int m;
  m = (d < 0) ? -d : d;
  return (m > MAX_GREY) ? MAX_GREY : m;
endfunction

// expected processed pixel at linear address a
function automatic int model_pxl(input int a, input bit filt, input bit vert);
  int r;
  int c;
  int near;
  int far;
  r = a / `EDGE_IMG_COLS;
  c = a % `EDGE_IMG_COLS;
  if (!filt)
    return int'(img[a]);           // pass through
  if (r == 0 || c == 0 || r == `EDGE_IMG_ROWS - 1 || c == `EDGE_IMG_COLS - 1)
    return 0;                      // black frame
  if (vert) begin
    near = tri_sum(px(r - 1, c + 1), px(r, c + 1), px(r + 1, c + 1));  // right column
    far  = tri_sum(px(r - 1, c - 1), px(r, c - 1), px(r + 1, c - 1));  // left column
  end else begin
    near = tri_sum(px(r + 1, c - 1), px(r + 1, c), px(r + 1, c + 1));  // row below
    far  = tri_sum(px(r - 1, c - 1), px(r - 1, c), px(r - 1, c + 1));  // row above
  end
  return cap_abs(near - far);
endfunction

`endif

// File: dv/tb_edge_proc.sv
`timescale 1ns/1ps
`include "edge_macros.svh"

module tb_edge_proc;
  import edge_pkg::*;

  localparam int        PXLS           = `EDGE_IMG_PXLS;
  localparam int        CLK_PERIOD     = 20;
  localparam int        FRAMES_PER_RUN = 3;
  localparam int        NUM_RUNS       = 7;   // engine runs over all tests
  // room per run for the frames, the load and a read back at two cycles per pixel
  localparam int        RUN_CYCLES     = (FRAMES_PER_RUN + 4) * PXLS;
  localparam int        WATCHDOG_CYC   = NUM_RUNS * RUN_CYCLES + 5000;
  localparam reg_addr_t CTRL           = reg_addr_t'(`EDGE_REG_CTRL);
  localparam reg_addr_t FRAMES         = reg_addr_t'(`EDGE_REG_FRAMES);

  logic      rst;         // clock
  logic      clk;         // active high reset
  logic      load_we;
  pxl_addr_t load_addr;
  pxl_t      load_pxl;
  pxl_addr_t rd_addr;
  pxl_t      rd_pxl;
  logic      cfg_we;
  reg_addr_t cfg_addr;
  reg_data_t cfg_wdata;
  reg_data_t cfg_rdata;
  logic      frame_done;

  pxl_t      img [0:PXLS-1];  // copy of the original memory
  integer    seed   = 42714;
  int        errors = 0;
  int        pulses = 0;      // frame_done pulses since reset
  reg_data_t rd_val;

  `include "tb_edge_model.svh"

  edge_proc_top UUT (.*);

  initial begin
    rst = 1'b0;
    forever #(CLK_PERIOD / 2) rst = ~rst;
  end

  // sampled mid cycle so each pulse counts once
  always @(negedge rst) begin
    if (!clk && frame_done)
      pulses <= pulses + 1;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("simulation timed out after %0d cycles, the engine never finished", WATCHDOG_CYC);
    $display("Test failures found");
    $finish;
  end

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(input reg_addr_t a, input reg_data_t d);
    @(posedge rst);
    #2;
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(posedge rst);
    #2;
    cfg_we = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t a, output reg_data_t d);
    @(posedge rst);
    #2;
    cfg_addr = a;
    @(negedge rst);
    d = cfg_rdata;   // combinational read
  endtask

  task automatic load_image();
    for (int i = 0; i < PXLS; i++) begin
      @(posedge rst);
      #2;
      load_we   = 1'b1;
      load_addr = pxl_addr_t'(i);
      load_pxl  = img[i];
    end
    @(posedge rst);
    #2;
    load_we = 1'b0;
  endtask

  task automatic make_random_image();
    for (int i = 0; i < PXLS; i++)
      img[i] = pxl_t'($random(seed));
  endtask

  // two pixel wide diagonal stripes that saturate both filters
  task automatic make_stripe_image();
    for (int i = 0; i < PXLS; i++)
      img[i] = (((i / `EDGE_IMG_COLS + i % `EDGE_IMG_COLS) >> 1) & 1) ? 8'hff : 8'h00;
  endtask

  task automatic wait_frames(input int n);
    int target;
    int cycles;
    target = pulses + n;
    cycles = 0;
    while (pulses < target && cycles < (n + 1) * PXLS + 100) begin
      @(negedge rst);
      cycles++;
    end
    if (pulses < target) begin
      errors++;
      $display("frame_done missing after %0d cycles, the engine seems stalled", cycles);
    end
  endtask

  // read the processed memory back against the model
  task automatic check_image(input bit filt, input bit vert, input string name);
    for (int a = 0; a < PXLS; a++) begin
      @(posedge rst);
      #2;
      rd_addr = pxl_addr_t'(a);
      @(posedge rst);
      @(negedge rst);
      check_val(rd_pxl, model_pxl(a, filt, vert), $sformatf("%s pixel %0d", name, a));
    end
  endtask

  task automatic run_mode(input bit filt, input bit vert, input string name);
    reg_data_t mode;
    mode = reg_data_t'({vert, filt});
    load_image();
    write_reg(CTRL, mode | 8'h04);   // run
    wait_frames(FRAMES_PER_RUN);
    write_reg(CTRL, mode);
    repeat (4) @(posedge rst);       // last write drains
    check_image(filt, vert, name);
  endtask

  initial begin
    clk       = 1'b1;
    load_we   = 1'b0;
    load_addr = '0;
    load_pxl  = '0;
    rd_addr   = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (16) @(posedge rst);
    #2;
    clk = 1'b0;

    read_reg(CTRL, rd_val);
    check_val(rd_val, 0, "control after reset");
    read_reg(FRAMES, rd_val);
    check_val(rd_val, 0, "frame count after reset");
    repeat (50) begin
      @(negedge rst);
      check_val(frame_done, 0, "frame_done while idle");
    end

    make_random_image();
    run_mode(1'b0, 1'b0, "pass-through");
    run_mode(1'b1, 1'b0, "horizontal random");
    make_stripe_image();
    run_mode(1'b1, 1'b0, "horizontal stripes");
    run_mode(1'b1, 1'b1, "vertical stripes");
    make_random_image();
    run_mode(1'b1, 1'b1, "vertical random");

    // new image so old vertical results cannot match
    make_random_image();
    load_image();
    // switch from horizontal to vertical while the engine runs
    write_reg(CTRL, 8'h05);
    wait_frames(FRAMES_PER_RUN);
    write_reg(CTRL, 8'h07);
    wait_frames(FRAMES_PER_RUN);
    write_reg(CTRL, 8'h03);
    repeat (4) @(posedge rst);
    check_image(1'b1, 1'b1, "mode change");

    read_reg(FRAMES, rd_val);
    check_val(rd_val, pulses % 256, "frame count");
    repeat (200) begin               // cfg_addr still on the frame register
      @(negedge rst);
      check_val(cfg_rdata, rd_val, "frame count after stop");
    end

    $display("done: %0d errors, %0d frames", errors, pulses);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: edge_proc_top.f
+incdir+hw
+incdir+dv
hw/edge_pkg.sv
hw/kernel_if.sv
hw/frame_ram.sv
hw/edge_cfg_regs.sv
hw/sobel_window.sv
hw/sobel_calc.sv
hw/edge_proc_top.sv
dv/tb_edge_proc.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_edge_proc -f edge_proc_top.f \
  > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_edge_proc > sim.log 2>&1 || { echo "simulation run failed, see sim.log"; exit 1; }
grep -q 'Test failures found' sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "no result in sim.log"; exit 1; }
echo "PASS"
